//--- rtl/ahb_pkg.sv
/*
 * AHB-lite definitions for the bridge front end.
 * Bus widths plus the transfer type and transfer size encodings.
 * Import with a wildcard in the module header where needed.
 */

package ahb_pkg;

  // Bus widths
  localparam int AHB_AW = 32;
  localparam int AHB_DW = 32;

  // HTRANS encoding
  // BUSY is treated like IDLE by the bridge
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  // HSIZE encoding, only up to a full word
  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } hsize_t;

endpackage : ahb_pkg

//--- rtl/apb_pkg.sv
/*
 * APB side definitions.
 * Master state encoding, the peripheral address map and the slave slots.
 * Shared by the APB master, the bus interface and the register banks.
 */

package apb_pkg;

  // APB bus widths
  localparam int APB_AW = 32;
  localparam int APB_DW = 32;

  // Master FSM states
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    SETUP  = 2'b01,
    ACCESS = 2'b10
  } apb_state_t;

  // Decoded target of a request
  typedef enum logic [1:0] {
    SLOT_NONE  = 2'b00,
    SLOT_BANK0 = 2'b01,
    SLOT_BANK1 = 2'b10
  } apb_slot_t;

  // ------------------------------------------------------------------------
  // Address map
  // ------------------------------------------------------------------------
  localparam logic [APB_AW-1:0] PERI_BASE  = 32'h0001_0000;
  localparam logic [APB_AW-1:0] BANK0_BASE = PERI_BASE + 32'h0000_0100;
  localparam logic [APB_AW-1:0] BANK1_BASE = PERI_BASE + 32'h0000_0200;
  // Eight 32-bit registers per bank
  localparam logic [APB_AW-1:0] BANK_SPAN  = 32'h0000_0020;

  // Last register of a bank is the read-only ID
  localparam logic [2:0] ID_REG_INDEX = 3'd7;

endpackage : apb_pkg

//--- rtl/x2p_req_if.sv
/*
 * Request/response channel between the AHB sampler and the APB master.
 * A request moves on req_valid and req_ready both high; the response is
 * a single rsp_valid pulse, one request outstanding at a time.
 */

`timescale 1ns/100ps

interface x2p_req_if import ahb_pkg::*; ();

  // Request, held stable until taken
  logic                  req_valid;
  logic                  req_ready;
  logic [AHB_AW-1:0]     req_addr;
  logic                  req_write;
  logic [AHB_DW-1:0]     req_wdata;
  logic [AHB_DW/8-1:0]   req_strb;
  logic [2:0]            req_prot;

  // Response pulse
  logic                  rsp_valid;
  logic [AHB_DW-1:0]     rsp_rdata;
  logic                  rsp_slverr;

  modport requester (
    output req_valid, req_addr, req_write, req_wdata, req_strb, req_prot,
    input  req_ready, rsp_valid, rsp_rdata, rsp_slverr
  );

  modport completer (
    input  req_valid, req_addr, req_write, req_wdata, req_strb, req_prot,
    output req_ready, rsp_valid, rsp_rdata, rsp_slverr
  );

endinterface : x2p_req_if

//--- rtl/apb_bus_if.sv
/*
 * APB bus between the APB master and a single peripheral.
 * One instance per register bank; psel alone marks SETUP, psel with
 * penable marks ACCESS until pready.
 */

`timescale 1ns/100ps

interface apb_bus_if import apb_pkg::*; ();

  // Master to slave
  logic                  psel;
  logic                  penable;
  logic [APB_AW-1:0]     paddr;
  logic                  pwrite;
  logic [APB_DW-1:0]     pwdata;
  logic [APB_DW/8-1:0]   pstrb;
  logic [2:0]            pprot;

  // Slave to master
  logic [APB_DW-1:0]     prdata;
  logic                  pready;
  logic                  pslverr;

  modport master (
    output psel, penable, paddr, pwrite, pwdata, pstrb, pprot,
    input  prdata, pready, pslverr
  );

  modport slave (
    input  psel, penable, paddr, pwrite, pwdata, pstrb, pprot,
    output prdata, pready, pslverr
  );

endinterface : apb_bus_if

//--- rtl/ahb_sampler.sv
/*
 * AHB-lite slave front end of the bridge.
 * Registers the address phase, captures write data, and hands one request
 * to the APB master. Stretches the data phase with hreadyout and plays out
 * the OKAY or two-cycle ERROR response.
 */

`timescale 1ns/100ps

module ahb_sampler import ahb_pkg::*; (
  input  logic                apb_clk,
  input  logic                rst_n,
  input  logic                hsel,
  input  logic [AHB_AW-1:0]   haddr,
  input  htrans_t             htrans,
  input  logic                hwrite,
  input  hsize_t              hsize,
  input  logic [3:0]          hprot,
  input  logic [AHB_DW-1:0]   hwdata,
  input  logic                hready,
  output logic                hreadyout,
  output logic                hresp,
  output logic [AHB_DW-1:0]   hrdata,
  x2p_req_if.requester        req
);

  // Transfer progress, one transfer at a time
  typedef enum logic [2:0] {
    S_IDLE = 3'd0,
    S_DATA = 3'd1,
    S_REQ  = 3'd2,
    S_WAIT = 3'd3,
    S_ERR  = 3'd4
  } smp_state_t;

  smp_state_t            state;
  logic                  addr_accept;
  logic [AHB_DW/8-1:0]   strb_next;
  logic                  valid_q;
  logic [AHB_AW-1:0]     addr_q;
  logic                  write_q;
  logic [AHB_DW/8-1:0]   strb_q;
  logic [2:0]            prot_q;
  logic [AHB_DW-1:0]     wdata_q;

  // Valid address phase, only taken while idle
  assign addr_accept = (state == S_IDLE) && hsel && hready &&
                       ((htrans == NONSEQ) || (htrans == SEQ));

  // Byte lanes from size and low address bits
  always_comb begin
    if (!hwrite) begin
      strb_next = '1;
    end else begin
      case (hsize)
        BYTE:    strb_next = 4'b0001 << haddr[1:0];
        HALF:    strb_next = haddr[1] ? 4'b1100 : 4'b0011;
        WORD:    strb_next = 4'b1111;
        default: strb_next = 4'b1111;
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // Control and response sequencing
  // ------------------------------------------------------------------------
  always_ff @(posedge apb_clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      hreadyout <= 1'b1;
      hresp     <= 1'b0;
      valid_q   <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          // Drop hresp after the second ERROR cycle
          hresp <= 1'b0;
          if (addr_accept) begin
            hreadyout <= 1'b0;
            state     <= S_DATA;
          end
        end
        S_DATA: begin
          valid_q <= 1'b1;
          state   <= S_REQ;
        end
        S_REQ: begin
          if (req.req_ready) begin
            valid_q <= 1'b0;
            state   <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (req.rsp_valid) begin
            if (req.rsp_slverr) begin
              // First ERROR cycle, hreadyout still low
              hresp <= 1'b1;
              state <= S_ERR;
            end else begin
              hreadyout <= 1'b1;
              state     <= S_IDLE;
            end
          end
        end
        S_ERR: begin
          hreadyout <= 1'b1;
          state     <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Payload capture
  always_ff @(posedge apb_clk) begin
    if (addr_accept) begin
      addr_q  <= haddr;
      write_q <= hwrite;
      strb_q  <= strb_next;
      // Instruction = not data, non-secure always set, privileged from hprot[1]
      prot_q  <= {~hprot[0], 1'b1, hprot[1]};
    end
    if (state == S_DATA) begin
      wdata_q <= hwdata;
    end
    if ((state == S_WAIT) && req.rsp_valid) begin
      hrdata <= req.rsp_rdata;
    end
  end

  assign req.req_valid = valid_q;
  assign req.req_addr  = addr_q;
  assign req.req_write = write_q;
  assign req.req_wdata = wdata_q;
  assign req.req_strb  = strb_q;
  assign req.req_prot  = prot_q;

endmodule : ahb_sampler

//--- rtl/apb_master_fsm.sv
/*
 * APB master of the bridge.
 * Takes one request at a time, decodes the target bank, runs SETUP and
 * ACCESS on that bank only, and returns read data and error as a one-cycle
 * response. Unmapped addresses are answered with an error right away.
 */

`timescale 1ns/100ps

module apb_master_fsm import apb_pkg::*; (
  input  logic          apb_clk,
  input  logic          rst_n,
  x2p_req_if.completer  req,
  apb_bus_if.master     bank0,
  apb_bus_if.master     bank1
);

  apb_state_t            state;
  apb_slot_t             slot;
  logic                  take;
  logic [APB_AW-1:0]     addr_q;
  logic                  write_q;
  logic [APB_DW-1:0]     wdata_q;
  logic [APB_DW/8-1:0]   strb_q;
  logic [2:0]            prot_q;
  logic                  sel_pready;
  logic                  sel_pslverr;
  logic [APB_DW-1:0]     sel_prdata;
  logic                  rsp_valid_q;
  logic                  rsp_slverr_q;
  logic [APB_DW-1:0]     rsp_rdata_q;

  // Window check against both banks
  function automatic apb_slot_t decode_slot(input logic [APB_AW-1:0] addr);
    apb_slot_t s;
    s = SLOT_NONE;
    if ((addr >= BANK0_BASE) && (addr < BANK0_BASE + BANK_SPAN)) begin
      s = SLOT_BANK0;
    end else if ((addr >= BANK1_BASE) && (addr < BANK1_BASE + BANK_SPAN)) begin
      s = SLOT_BANK1;
    end
    return s;
  endfunction

  assign req.req_ready = (state == IDLE);
  assign take          = req.req_valid && (state == IDLE);

  // Return path from the selected bank
  assign sel_pready  = (slot == SLOT_BANK1) ? bank1.pready  : bank0.pready;
  assign sel_pslverr = (slot == SLOT_BANK1) ? bank1.pslverr : bank0.pslverr;
  assign sel_prdata  = (slot == SLOT_BANK1) ? bank1.prdata  : bank0.prdata;

  // ------------------------------------------------------------------------
  // Phase sequencing
  // ------------------------------------------------------------------------
  always_ff @(posedge apb_clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= IDLE;
      slot         <= SLOT_NONE;
      rsp_valid_q  <= 1'b0;
      rsp_slverr_q <= 1'b0;
    end else begin
      // Response is a single pulse
      rsp_valid_q <= 1'b0;
      case (state)
        IDLE: begin
          if (take) begin
            slot <= decode_slot(req.req_addr);
            if (decode_slot(req.req_addr) == SLOT_NONE) begin
              // Nothing behind this address
              rsp_valid_q  <= 1'b1;
              rsp_slverr_q <= 1'b1;
            end else begin
              state <= SETUP;
            end
          end
        end
        SETUP: state <= ACCESS;
        ACCESS: begin
          if (sel_pready) begin
            rsp_valid_q  <= 1'b1;
            rsp_slverr_q <= sel_pslverr;
            state        <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Request fields, stable from SETUP to completion
  always_ff @(posedge apb_clk) begin
    if (take) begin
      addr_q  <= req.req_addr;
      write_q <= req.req_write;
      wdata_q <= req.req_wdata;
      strb_q  <= req.req_strb;
      prot_q  <= req.req_prot;
    end
    if ((state == ACCESS) && sel_pready) begin
      rsp_rdata_q <= sel_prdata;
    end
  end

  assign req.rsp_valid  = rsp_valid_q;
  assign req.rsp_slverr = rsp_slverr_q;
  assign req.rsp_rdata  = rsp_rdata_q;

  // Both buses share address and data, psel picks the bank
  assign bank0.psel    = (state != IDLE) && (slot == SLOT_BANK0);
  assign bank0.penable = (state == ACCESS) && (slot == SLOT_BANK0);
  assign bank0.paddr   = addr_q;
  assign bank0.pwrite  = write_q;
  assign bank0.pwdata  = wdata_q;
  assign bank0.pstrb   = strb_q;
  assign bank0.pprot   = prot_q;

  assign bank1.psel    = (state != IDLE) && (slot == SLOT_BANK1);
  assign bank1.penable = (state == ACCESS) && (slot == SLOT_BANK1);
  assign bank1.paddr   = addr_q;
  assign bank1.pwrite  = write_q;
  assign bank1.pwdata  = wdata_q;
  assign bank1.pstrb   = strb_q;
  assign bank1.pprot   = prot_q;

endmodule : apb_master_fsm

//--- rtl/apb_reg_bank.sv
/*
 * APB register bank peripheral.
 * Seven read/write registers plus a read-only ID register, byte strobes,
 * a fixed number of wait states and refusal of unprivileged writes.
 */

`timescale 1ns/100ps

module apb_reg_bank import apb_pkg::*; #(
  parameter int unsigned       WAIT_STATES = 0,
  parameter logic [APB_DW-1:0] ID_VALUE    = 32'hB0B0_0001
) (
  input  logic       apb_clk,
  input  logic       rst_n,
  apb_bus_if.slave   apb
);

  localparam int NUM_RW = int'(ID_REG_INDEX);
  localparam int CNT_W  = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  logic [APB_DW-1:0]   regs [NUM_RW];
  logic [CNT_W-1:0]    wait_cnt;
  logic [2:0]          reg_idx;
  logic                access;
  logic                wr_err;
  logic                wr_en;

  // Word index inside the bank
  assign reg_idx = apb.paddr[4:2];
  assign access  = apb.psel && apb.penable;

  // pready on the (WAIT_STATES+1)th ACCESS cycle
  assign apb.pready = access && (wait_cnt == CNT_W'(WAIT_STATES));

  always_ff @(posedge apb_clk or negedge rst_n) begin
    if (!rst_n) begin
      wait_cnt <= '0;
    end else if (access && !apb.pready) begin
      wait_cnt <= wait_cnt + CNT_W'(1);
    end else begin
      wait_cnt <= '0;
    end
  end

  // ------------------------------------------------------------------------
  // Write side
  // ------------------------------------------------------------------------
  // ID register and unprivileged writes are refused
  assign wr_err = apb.pwrite && ((reg_idx == ID_REG_INDEX) || !apb.pprot[0]);
  assign wr_en  = apb.pready && apb.pwrite && !wr_err;

  assign apb.pslverr = apb.pready && wr_err;

  always_ff @(posedge apb_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_RW; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      // Merge only the strobed bytes
      for (int b = 0; b < APB_DW / 8; b++) begin
        if (apb.pstrb[b]) begin
          regs[reg_idx][8*b +: 8] <= apb.pwdata[8*b +: 8];
        end
      end
    end
  end

  // Read side, always OKAY
  assign apb.prdata = (reg_idx == ID_REG_INDEX) ? ID_VALUE : regs[reg_idx];

endmodule : apb_reg_bank

//--- rtl/x2p_top.sv
/*
 * Peripheral subsystem top level.
 * AHB-lite slave port in front of the bridge, with two APB register banks
 * behind it. Bank wait states and ID values are set here.
 */

`timescale 1ns/100ps

module x2p_top import ahb_pkg::*; #(
  parameter int unsigned       BANK0_WAIT = 0,
  parameter int unsigned       BANK1_WAIT = 2,
  parameter logic [AHB_DW-1:0] BANK0_ID   = 32'hB0B0_0001,
  parameter logic [AHB_DW-1:0] BANK1_ID   = 32'hB0B0_0002
) (
  input  logic                apb_clk,
  input  logic                rst_n,
  // AHB-lite slave
  input  logic                hsel,
  input  logic [AHB_AW-1:0]   haddr,
  input  htrans_t             htrans,
  input  logic                hwrite,
  input  hsize_t              hsize,
  input  logic [3:0]          hprot,
  input  logic [AHB_DW-1:0]   hwdata,
  input  logic                hready,
  output logic                hreadyout,
  output logic                hresp,
  output logic [AHB_DW-1:0]   hrdata
);

  // Bridge request channel and per-bank APB buses
  x2p_req_if x2p_req ();
  apb_bus_if bank0_bus ();
  apb_bus_if bank1_bus ();

  ahb_sampler u_sampler (
    .apb_clk   (apb_clk),
    .rst_n     (rst_n),
    .hsel      (hsel),
    .haddr     (haddr),
    .htrans    (htrans),
    .hwrite    (hwrite),
    .hsize     (hsize),
    .hprot     (hprot),
    .hwdata    (hwdata),
    .hready    (hready),
    .hreadyout (hreadyout),
    .hresp     (hresp),
    .hrdata    (hrdata),
    .req       (x2p_req.requester)
  );

  apb_master_fsm u_apb_master (
    .apb_clk (apb_clk),
    .rst_n   (rst_n),
    .req     (x2p_req.completer),
    .bank0   (bank0_bus.master),
    .bank1   (bank1_bus.master)
  );

  // ------------------------------------------------------------------------
  // Peripherals
  // ------------------------------------------------------------------------
  apb_reg_bank #(
    .WAIT_STATES (BANK0_WAIT),
    .ID_VALUE    (BANK0_ID)
  ) u_bank0 (
    .apb_clk (apb_clk),
    .rst_n   (rst_n),
    .apb     (bank0_bus.slave)
  );

  // Slower bank
  apb_reg_bank #(
    .WAIT_STATES (BANK1_WAIT),
    .ID_VALUE    (BANK1_ID)
  ) u_bank1 (
    .apb_clk (apb_clk),
    .rst_n   (rst_n),
    .apb     (bank1_bus.slave)
  );

endmodule : x2p_top

//--- test/tb_x2p.sv
/*
 * Self-checking testbench for the AHB-lite to APB peripheral subsystem.
 * Runs single AHB transfers into x2p_top, predicts every response with a
 * register model of both banks and compares in a separate process.
 */

`timescale 1ns/100ps

module tb_x2p import ahb_pkg::*; ;

  // Address map and ID values of the default configuration
  localparam logic [31:0] PERI_ADDR  = 32'h0001_0000;
  localparam logic [31:0] BANK0_ADDR = 32'h0001_0100;
  localparam logic [31:0] BANK1_ADDR = 32'h0001_0200;
  localparam logic [31:0] SPAN       = 32'h0000_0020;
  localparam logic [31:0] ID0        = 32'hB0B0_0001;
  localparam logic [31:0] ID1        = 32'hB0B0_0002;
  localparam int          XFER_TIMEOUT = 40;

  logic          apb_clk;
  logic          rst_n;
  logic          hsel;
  logic [31:0]   haddr;
  htrans_t       htrans;
  logic          hwrite;
  hsize_t        hsize;
  logic [3:0]    hprot;
  logic [31:0]   hwdata;
  logic          hready;
  logic          hreadyout;
  logic          hresp;
  logic [31:0]   hrdata;

  integer        seed = 32'h6db3_4ced;
  int            errors = 0;
  int            xfers = 0;

  // Register model, index 7 of each bank is the ID and never stored
  logic [31:0]   model [2][8];

  // Expected and observed results, one entry per transfer
  logic          exp_err_q [$];
  logic          rd_chk_q [$];
  logic [31:0]   exp_rdata_q [$];
  logic          act_resp_q [$];
  logic          act_lead_q [$];
  logic [31:0]   act_rdata_q [$];

  x2p_top u_dut (
    .apb_clk   (apb_clk),
    .rst_n     (rst_n),
    .hsel      (hsel),
    .haddr     (haddr),
    .htrans    (htrans),
    .hwrite    (hwrite),
    .hsize     (hsize),
    .hprot     (hprot),
    .hwdata    (hwdata),
    .hready    (hready),
    .hreadyout (hreadyout),
    .hresp     (hresp),
    .hrdata    (hrdata)
  );

  initial begin
    apb_clk = 1'b0;
    forever #4 apb_clk = ~apb_clk;
  end

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  function automatic logic [31:0] bank_base(input int b);
    return (b == 0) ? BANK0_ADDR : BANK1_ADDR;
  endfunction

  // Holes inside the peripheral window, outside both banks
  function automatic logic [31:0] hole_addr(input int k);
    case (k)
      0:       return PERI_ADDR;
      1:       return PERI_ADDR + 32'h0F0;
      2:       return BANK0_ADDR + SPAN;
      3:       return BANK1_ADDR - 32'h4;
      4:       return BANK1_ADDR + SPAN + 32'hDC;
      default: return PERI_ADDR + 32'h800;
    endcase
  endfunction

  // ------------------------------------------------------------------------
  // Reference model: response flag, read data and register update
  // ------------------------------------------------------------------------
  function automatic void ahb_expect(input logic [31:0] addr, input hsize_t size,
                                     input logic write, input logic priv,
                                     input logic [31:0] wdata,
                                     output logic err, output logic [31:0] rdata);
    int bank;
    int idx;
    int nbytes;
    int first;
    bank = -1;
    if ((addr >= BANK0_ADDR) && (addr < BANK0_ADDR + SPAN)) begin
      bank = 0;
    end else if ((addr >= BANK1_ADDR) && (addr < BANK1_ADDR + SPAN)) begin
      bank = 1;
    end
    idx   = int'(addr[4:2]);
    err   = 1'b0;
    rdata = '0;
    if (bank < 0) begin
      err = 1'b1;
    end else begin
      if (idx == 7) begin
        rdata = (bank == 0) ? ID0 : ID1;
      end else begin
        rdata = model[bank][idx];
      end
      if (write && ((idx == 7) || !priv)) begin
        err = 1'b1;
      end else if (write) begin
        // Naturally aligned lanes covered by the transfer size
        nbytes = 1 << int'(size);
        first  = int'(addr[1:0]) / nbytes * nbytes;
        for (int b = 0; b < 4; b++) begin
          if ((b >= first) && (b < first + nbytes)) begin
            model[bank][idx][8*b +: 8] = wdata[8*b +: 8];
          end
        end
      end
    end
  endfunction

  // One AHB transfer, address phase then data phase until hreadyout
  task automatic ahb_xfer(input logic [31:0] addr, input hsize_t size,
                          input logic write, input logic priv, input logic [31:0] wdata);
    logic        exp_err;
    logic [31:0] exp_rdata;
    logic        lead;
    int          cycles;
    ahb_expect(addr, size, write, priv, wdata, exp_err, exp_rdata);
    @(posedge apb_clk);
    hsel   <= 1'b1;
    haddr  <= addr;
    htrans <= NONSEQ;
    hwrite <= write;
    hsize  <= size;
    hprot  <= priv ? 4'b0011 : 4'b0001;
    @(posedge apb_clk);
    hsel   <= 1'b0;
    htrans <= IDLE;
    hwdata <= wdata;
    lead   = 1'b0;
    cycles = 0;
    @(negedge apb_clk);
    while (!hreadyout && (cycles < XFER_TIMEOUT)) begin
      // First ERROR cycle shows hresp with hreadyout low
      if (hresp) begin
        lead = 1'b1;
      end
      cycles++;
      @(negedge apb_clk);
    end
    if (!hreadyout) begin
      $display("Timeout: hreadyout stayed low for the transfer to %h", addr);
      $display("Test FAILED");
      $finish;
    end else begin
      xfers++;
      exp_err_q.push_back(exp_err);
      rd_chk_q.push_back(!write && !exp_err);
      exp_rdata_q.push_back(exp_rdata);
      act_resp_q.push_back(hresp);
      act_lead_q.push_back(lead);
      act_rdata_q.push_back(hrdata);
    end
  endtask

  // Compare process
  always @(posedge apb_clk) begin
    if (exp_err_q.size() > 0) begin
      check_value("hresp (wait cycle)", {31'b0, exp_err_q[0]}, {31'b0, act_lead_q[0]});
      check_value("hresp", {31'b0, exp_err_q[0]}, {31'b0, act_resp_q[0]});
      if (rd_chk_q[0]) begin
        check_value("hrdata", exp_rdata_q[0], act_rdata_q[0]);
      end
      void'(exp_err_q.pop_front());
      void'(rd_chk_q.pop_front());
      void'(exp_rdata_q.pop_front());
      void'(act_resp_q.pop_front());
      void'(act_lead_q.pop_front());
      void'(act_rdata_q.pop_front());
    end
  end

  // ------------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------------
  initial begin
    int          bank;
    int          idx;
    int          cycles;
    logic [31:0] addr;
    for (int b = 0; b < 2; b++) begin
      for (int i = 0; i < 8; i++) begin
        model[b][i] = '0;
      end
    end
    rst_n  = 1'b0;
    hsel   = 1'b0;
    haddr  = '0;
    htrans = IDLE;
    hwrite = 1'b0;
    hsize  = WORD;
    hprot  = 4'b0011;
    hwdata = '0;
    hready = 1'b1;
    repeat (3) @(posedge apb_clk);
    rst_n <= 1'b1;
    @(negedge apb_clk);
    check_value("hreadyout", 32'd1, {31'b0, hreadyout});
    check_value("hresp", 32'd0, {31'b0, hresp});

    // Reset values, ID registers included
    for (int b = 0; b < 2; b++) begin
      for (int i = 0; i < 8; i++) begin
        ahb_xfer(bank_base(b) + 32'(4 * i), WORD, 1'b0, 1'b1, 32'h0);
      end
    end

    // Random word writes with read-back, both wait-state settings
    repeat (24) begin
      bank = $random(seed) & 1;
      idx  = $unsigned($random(seed)) % 7;
      addr = bank_base(bank) + 32'(4 * idx);
      ahb_xfer(addr, WORD, 1'b1, 1'b1, $random(seed));
      ahb_xfer(addr, WORD, 1'b0, 1'b1, 32'h0);
    end

    // Byte and halfword merges at every legal offset
    for (int b = 0; b < 2; b++) begin
      addr = bank_base(b) + 32'(4 * (b + 1));
      ahb_xfer(addr, WORD, 1'b1, 1'b1, 32'hA5A5_5A5A);
      for (int off = 0; off < 4; off++) begin
        ahb_xfer(addr + 32'(off), BYTE, 1'b1, 1'b1, $random(seed));
        ahb_xfer(addr, WORD, 1'b0, 1'b1, 32'h0);
      end
      for (int off = 0; off < 4; off += 2) begin
        ahb_xfer(addr + 32'(off), HALF, 1'b1, 1'b1, $random(seed));
        ahb_xfer(addr, WORD, 1'b0, 1'b1, 32'h0);
      end
    end

    // ID registers refuse writes
    for (int b = 0; b < 2; b++) begin
      ahb_xfer(bank_base(b) + 32'h1C, WORD, 1'b1, 1'b1, 32'hDEAD_BEEF);
      ahb_xfer(bank_base(b) + 32'h1C, WORD, 1'b0, 1'b1, 32'h0);
    end

    // Unprivileged writes fail, unprivileged reads pass
    ahb_xfer(BANK0_ADDR + 32'h8, WORD, 1'b1, 1'b0, 32'h1234_5678);
    ahb_xfer(BANK0_ADDR + 32'h8, WORD, 1'b0, 1'b1, 32'h0);
    ahb_xfer(BANK1_ADDR + 32'h14, BYTE, 1'b1, 1'b0, 32'hFFFF_FFFF);
    ahb_xfer(BANK1_ADDR + 32'h14, WORD, 1'b0, 1'b0, 32'h0);

    // Unmapped holes, then a normal access
    for (int k = 0; k < 6; k++) begin
      ahb_xfer(hole_addr(k), WORD, 1'b0, 1'b1, 32'h0);
      ahb_xfer(hole_addr(k), WORD, 1'b1, 1'b1, $random(seed));
    end
    ahb_xfer(BANK1_ADDR, WORD, 1'b1, 1'b1, 32'h0BAD_F00D);
    ahb_xfer(BANK1_ADDR, WORD, 1'b0, 1'b1, 32'h0);

    // Let the compare process drain
    cycles = 0;
    while ((exp_err_q.size() > 0) && (cycles < 10)) begin
      @(negedge apb_clk);
      cycles++;
    end
    if (exp_err_q.size() > 0) begin
      errors++;
      $display("Compare process left %0d transfers unchecked", exp_err_q.size());
    end
    $display("Transfers: %0d, errors: %0d", xfers, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule : tb_x2p

//--- compile.f
rtl/ahb_pkg.sv
rtl/apb_pkg.sv
rtl/x2p_req_if.sv
rtl/apb_bus_if.sv
rtl/ahb_sampler.sv
rtl/apb_master_fsm.sv
rtl/apb_reg_bank.sv
rtl/x2p_top.sv
test/tb_x2p.sv

//--- Makefile
# Verilator flow for the AHB-lite to APB peripheral subsystem

VERILATOR ?= verilator
FLAGS     ?= --timing -j 0
TOP       ?= tb_x2p
RTL_TOP   ?= x2p_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint build sim clean

all: sim

# Lint the design from its top level
lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail is taken from the log
sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Test OK" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
